// ==== dv/radio_properties.sv ====
module radio_properties (
  input logic              clk,
  input logic              rst_i,
  input logic              cmd_ack_i,
  input logic [23:0]       rx_tdata_i,
  input logic              rx_tvalid_i,
  input logic              rx_tlast_i,
  input logic              rx_tready_i,
  input logic              tx_cw_key_i,
  input radio_pkg::tx_iq_s tx_iq_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // ---------------------------------------------------------------------------
  // command and stream handshakes
  // ---------------------------------------------------------------------------

  // ack is a single-cycle pulse
  ack_single: assert property (@(posedge clk) disable iff (rst_i)
    cmd_ack_i |=> !cmd_ack_i)
    else $error("cmd_ack_o high for two cycles in a row");

  last_in_valid: assert property (@(posedge clk) disable iff (rst_i)
    rx_tlast_i |-> rx_tvalid_i)
    else $error("rx_tlast_o high without rx_tvalid_o");

  // stalled beat keeps valid and data
  data_held: assert property (@(posedge clk) disable iff (rst_i)
    (rx_tvalid_i && !rx_tready_i) |=> (rx_tvalid_i && $stable(rx_tdata_i)))
    else $error("rx_tdata_o changed while stalled");

  // ramp is back at zero when the key drops
  key_fall_zero: assert property (@(posedge clk) disable iff (rst_i)
    $fell(tx_cw_key_i) |-> ($past(tx_iq_i.i) == 16'sd0))
    else $error("tx_cw_key_o fell while tx_iq_o.i was not zero");

endmodule

bind radio_top radio_properties i_properties (
  .clk         (clk),
  .rst_i       (rst_i),
  .cmd_ack_i   (cmd_ack_o),
  .rx_tdata_i  (rx_tdata_o),
  .rx_tvalid_i (rx_tvalid_o),
  .rx_tlast_i  (rx_tlast_o),
  .rx_tready_i (rx_tready_i),
  .tx_cw_key_i (tx_cw_key_o),
  .tx_iq_i     (tx_iq_o)
);

// ==== dv/radio_tb.sv ====
`include "radio_consts.svh"

module radio_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic                   clk;
  logic                   rst_i;
  logic                   cmd_rqst_i;
  logic [5:0]             cmd_addr_i;
  radio_pkg::cmd_word_u   cmd_data_i;
  logic                   cmd_ack_o;
  logic                   cw_keydown_i;
  logic                   tx_cw_key_o;
  radio_pkg::tx_iq_s      tx_tdata_i;
  logic                   tx_tvalid_i;
  logic                   tx_req_i;
  logic                   tx_tready_o;
  logic                   tx_hang_o;
  radio_pkg::tx_iq_s      tx_iq_o;
  logic                   rx_strobe_i;
  radio_pkg::rx_bank_s    rx_bank_i;
  logic [23:0]            rx_tdata_o;
  logic                   rx_tvalid_o;
  logic                   rx_tlast_o;
  logic                   rx_tready_i;
  radio_pkg::phase_bank_s phase_o;
  logic [5:0]             rate_o;

  integer seed = 40996;
  int     tests;
  int     checks;
  int     errors;
  int     err_mark;

  // expected phase words and the config they depend on
  logic [31:0] exp_tx;
  logic [31:0] exp_rx [`RADIO_NUM_RX];
  logic        exp_duplex;
  logic [4:0]  exp_last;

  radio_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ---------------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------------

  // edge, then the drive point
  task automatic tick();
    @(posedge clk);
    #10;
  endtask

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %s finished with %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  // Hz times 2^57/fclk, rounded, bits 56:25
  function automatic logic [31:0] phase_of(input logic [31:0] hz);
    logic [63:0] prod;
    prod = 64'(hz) * 64'(`RADIO_FREQ_MULT) + 64'(`RADIO_FREQ_ROUND);
    return prod[56:25];
  endfunction

  task automatic write_ctrl(input logic [1:0] rate, input logic [4:0] last,
                            input logic duplex);
    radio_pkg::cmd_word_u w;
    w = '0;
    w.ctrl.rx_rate   = rate;
    w.ctrl.last_chan = last;
    w.ctrl.duplex    = duplex;
    cmd_addr_i = `RADIO_ADDR_CTRL;
    cmd_data_i = w;
    cmd_rqst_i = 1'b1;
    tick();
    cmd_rqst_i = 1'b0;
    exp_duplex = duplex;
    exp_last   = last;
  endtask

  task automatic write_vna(input logic vna);
    radio_pkg::cmd_word_u w;
    w = '0;
    w.ctrl.vna = vna;
    cmd_addr_i = `RADIO_ADDR_VNA;
    cmd_data_i = w;
    cmd_rqst_i = 1'b1;
    tick();
    cmd_rqst_i = 1'b0;
  endtask

  task automatic check_phases();
    check_val("phase_o.tx", phase_o.tx, exp_tx);
    for (int n = 0; n < `RADIO_NUM_RX; n++) begin
      check_val($sformatf("phase_o.rx[%0d]", n), phase_o.rx[n], exp_rx[n]);
    end
  endtask

  task automatic write_freq(input logic [5:0] addr, input logic [31:0] hz);
    int          cyc;
    int          idx;
    logic        simplex;
    logic [31:0] word;
    word    = phase_of(hz);
    simplex = !exp_duplex && (exp_last == 5'd0);
    idx     = addr - `RADIO_ADDR_RX0FREQ;
    cmd_addr_i      = addr;
    cmd_data_i.freq = hz;
    cmd_rqst_i      = 1'b1;
    tick();
    cyc = 1;
    while (!cmd_ack_o && cyc < 10) begin
      tick();
      cyc++;
    end
    cmd_rqst_i = 1'b0;
    if (!cmd_ack_o) begin
      note_failure("no acknowledge within 10 cycles of a frequency write");
    end else begin
      check_val("cmd_ack_o cycles", cyc, 3);
      // routing as seen by the host
      if (addr == `RADIO_ADDR_TXFREQ) begin
        exp_tx = word;
        if (simplex) begin
          exp_rx[0] = word;
        end
      end else if (addr == `RADIO_ADDR_RX0FREQ) begin
        exp_rx[0] = simplex ? exp_tx : word;
      end else if (idx < `RADIO_NUM_RX) begin
        exp_rx[idx] = word;
      end
      tick();
      check_val("cmd_ack_o", cmd_ack_o, 1'b0);
      check_phases();
    end
  endtask

  // ready toggles at random, beats are counted on valid and ready
  task automatic collect_packet(input radio_pkg::rx_bank_s bank);
    logic [23:0] exp_data [$];
    int          beat;
    int          cyc;
    logic        done;
    for (int n = 0; n <= exp_last; n++) begin
      exp_data.push_back((n < `RADIO_NUM_RX) ? bank.ch[n].i : 24'd0);
      exp_data.push_back((n < `RADIO_NUM_RX) ? bank.ch[n].q : 24'd0);
    end
    beat = 0;
    cyc  = 0;
    done = 1'b0;
    while (!done && cyc < 100) begin
      rx_tready_i = (($random(seed) & 3) != 0);
      if (rx_tvalid_o && rx_tready_i) begin
        check_val("rx_tdata_o", rx_tdata_o, exp_data[beat]);
        check_val("rx_tlast_o", rx_tlast_o, beat == exp_data.size() - 1);
        beat++;
        done = (beat == exp_data.size());
      end
      tick();
      cyc++;
    end
    rx_tready_i = 1'b1;
    if (!done) begin
      note_failure("upstream packet did not complete within 100 cycles");
    end
    check_val("rx_tvalid_o", rx_tvalid_o, 1'b0);
  endtask

  // ---------------------------------------------------------------------------
  // directed tests
  // ---------------------------------------------------------------------------

  task automatic test_reset();
    check_val("cmd_ack_o", cmd_ack_o, 1'b0);
    check_val("rx_tvalid_o", rx_tvalid_o, 1'b0);
    check_val("rx_tlast_o", rx_tlast_o, 1'b0);
    check_val("tx_cw_key_o", tx_cw_key_o, 1'b0);
    check_val("rate_o", rate_o, 6'd40);
    check_val("tx_iq_o", tx_iq_o, 32'd0);
    check_phases();
    end_test("reset");
  endtask

  task automatic test_rate();
    logic [5:0] rate_tab [4];
    rate_tab = '{6'd40, 6'd20, 6'd10, 6'd5};
    for (int r = 0; r < 4; r++) begin
      write_ctrl(2'(r), 5'd0, 1'b0);
      tick();
      check_val("rate_o", rate_o, rate_tab[r]);
    end
    end_test("rate");
  endtask

  task automatic test_freq();
    logic [5:0] addrs [3];
    addrs = '{6'h01, 6'h03, 6'h04};
    // duplex so 0x01 touches only tx
    write_ctrl(2'd0, 5'd2, 1'b1);
    tick();
    foreach (addrs[k]) begin
      write_freq(addrs[k], $unsigned($random(seed)) % 32'd61440000);
    end
    end_test("freq");
  endtask

  task automatic test_routing();
    write_ctrl(2'd0, 5'd0, 1'b0);
    tick();
    // simplex on channel 0
    // rx0 still differs from tx here, so the copy is visible
    write_freq(6'h02, $unsigned($random(seed)) % 32'd61440000);
    write_freq(6'h01, $unsigned($random(seed)) % 32'd61440000);
    // duplex, rx0 gets its own word
    write_ctrl(2'd0, 5'd0, 1'b1);
    tick();
    write_freq(6'h02, $unsigned($random(seed)) % 32'd61440000);
    end_test("routing");
  endtask

  task automatic test_upstream();
    radio_pkg::rx_bank_s bank;
    write_ctrl(2'd0, 5'd2, 1'b1);
    tick();
    for (int pkt = 0; pkt < 2; pkt++) begin
      for (int n = 0; n < `RADIO_NUM_RX; n++) begin
        bank.ch[n].i = 24'($random(seed));
        bank.ch[n].q = 24'($random(seed));
      end
      rx_bank_i = bank;
      if (pkt == 1) begin
        // strobe still high, no new packet
        repeat (4) begin
          tick();
          check_val("rx_tvalid_o", rx_tvalid_o, 1'b0);
        end
        rx_strobe_i = 1'b0;
        tick();
      end
      rx_strobe_i = 1'b1;
      rx_tready_i = 1'b1;
      tick();
      collect_packet(bank);
    end
    rx_strobe_i = 1'b0;
    tick();
    end_test("upstream");
  endtask

  task automatic test_baseband();
    radio_pkg::tx_iq_s s1;
    radio_pkg::tx_iq_s s2;
    int                rise_cyc;
    int                cyc;
    logic [15:0]       bound;
    s1 = radio_pkg::tx_iq_s'($random(seed));
    s2 = radio_pkg::tx_iq_s'($random(seed));
    tx_tdata_i  = s1;
    tx_tvalid_i = 1'b1;
    tx_req_i    = 1'b1;
    tick();
    check_val("tx_tready_o", tx_tready_o, 1'b1);
    check_val("tx_hang_o", tx_hang_o, 1'b1);
    check_val("tx_iq_o", tx_iq_o, s1);
    // no request, no latch
    tx_tdata_i = s2;
    tx_req_i   = 1'b0;
    tick();
    check_val("tx_tready_o", tx_tready_o, 1'b0);
    check_val("tx_iq_o", tx_iq_o, s1);
    tx_tvalid_i = 1'b0;
    tick();
    check_val("tx_hang_o", tx_hang_o, 1'b0);

    write_vna(1'b1);
    tick();
    check_val("tx_iq_o.i", tx_iq_o.i, 16'h4D80);
    check_val("tx_iq_o.q", tx_iq_o.q, 16'h0000);
    write_vna(1'b0);
    tick();
    check_val("tx_iq_o", tx_iq_o, s1);

    // 64 cycles of keydown, ramp bounded by cycles since the key rose
    cw_keydown_i = 1'b1;
    rise_cyc     = 0;
    for (cyc = 1; cyc <= 64; cyc++) begin
      tick();
      if (tx_cw_key_o && rise_cyc == 0) begin
        rise_cyc = cyc;
      end
      if (rise_cyc != 0) begin
        bound = 16'(cyc - rise_cyc) >> 4;
        checks++;
        assert ($unsigned(tx_iq_o.i) <= bound) else begin
          $display("Fail tx_iq_o.i got %h above bound %h", tx_iq_o.i, bound);
          errors++;
        end
        check_val("tx_iq_o.q", tx_iq_o.q, 16'h0000);
      end
    end
    checks++;
    assert (rise_cyc != 0 && rise_cyc <= 2) else begin
      note_failure("cw key did not rise within two cycles of keydown");
    end
    cw_keydown_i = 1'b0;
    cyc = 0;
    while (tx_cw_key_o && cyc < 200) begin
      tick();
      cyc++;
    end
    if (tx_cw_key_o) begin
      note_failure("cw key still high 200 cycles after release");
    end else begin
      check_val("tx_iq_o", tx_iq_o, s1);
    end
    end_test("baseband");
  endtask

  // ---------------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------------

  initial begin
    rst_i        = 1'b1;
    cmd_rqst_i   = 1'b0;
    cmd_addr_i   = 6'd0;
    cmd_data_i   = '0;
    cw_keydown_i = 1'b0;
    tx_tdata_i   = '0;
    tx_tvalid_i  = 1'b0;
    tx_req_i     = 1'b0;
    rx_strobe_i  = 1'b0;
    rx_bank_i    = '0;
    rx_tready_i  = 1'b1;
    exp_tx       = 32'd0;
    exp_duplex   = 1'b0;
    exp_last     = 5'd0;
    foreach (exp_rx[n]) begin
      exp_rx[n] = 32'd0;
    end
    repeat (10) tick();
    rst_i = 1'b0;
    tick();

    test_reset();
    test_rate();
    test_freq();
    test_routing();
    test_upstream();
    test_baseband();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== include/radio_consts.svh ====
`ifndef RADIO_CONSTS_SVH
`define RADIO_CONSTS_SVH

// ---------------------------------------------------------------------------
// receiver count and clock-derived constants, 76.8 MHz only
// ---------------------------------------------------------------------------

// number of receivers fed by the decimators
`define RADIO_NUM_RX       3

// 2^57 / 76.8e6, scales Hz to phase increment
`define RADIO_FREQ_MULT    32'd1876499845
// 2^24, rounding term added before the slice
`define RADIO_FREQ_ROUND   32'd16777216

// decimation values, each rate halves the one before
`define RADIO_RATE48       6'd40
`define RADIO_RATE96       6'd20
`define RADIO_RATE192      6'd10
`define RADIO_RATE384      6'd5

// top of the cw key ramp, 16x the vna carrier
`define RADIO_CW_MAX       19'h4D800
// i level for constant carrier in vna mode
`define RADIO_VNA_LEVEL    16'h4D80

// ---------------------------------------------------------------------------
// command addresses
// ---------------------------------------------------------------------------
`define RADIO_ADDR_CTRL    6'h00
`define RADIO_ADDR_TXFREQ  6'h01
`define RADIO_ADDR_RX0FREQ 6'h02
`define RADIO_ADDR_MAXFREQ 6'h08
`define RADIO_ADDR_VNA     6'h09

`endif

// ==== sim.f ====
+incdir+include
src/radio_pkg.sv
src/radio_cmd_slave.sv
src/radio_phase_bank.sv
src/radio_rx_upstream.sv
src/radio_cw_shaper.sv
src/radio_tx_baseband.sv
src/radio_top.sv
dv/radio_properties.sv
dv/radio_tb.sv

// ==== src/radio_cmd_slave.sv ====
`include "radio_consts.svh"

module radio_cmd_slave (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  cmd_rqst_i,
  input  logic [5:0]            cmd_addr_i,
  input  radio_pkg::cmd_word_u  cmd_data_i,
  output logic                  cmd_ack_o,
  output radio_pkg::radio_cfg_s cfg_o,
  output radio_pkg::freq_wr_s   freq_wr_o,
  output logic [5:0]            rate_o
);

  // gray-ish sequence, one bit flips per step
  localparam logic [1:0] ST_IDLE  = 2'b00;
  localparam logic [1:0] ST_FREQ1 = 2'b01;
  localparam logic [1:0] ST_FREQ2 = 2'b11;
  localparam logic [1:0] ST_FREQ3 = 2'b10;

  logic [1:0]            state_q;
  logic [1:0]            state_d;
  logic                  is_freq_addr;
  logic [63:0]           freq_prod;
  logic [31:0]           phase_q;
  logic [5:0]            addr_q;
  radio_pkg::radio_cfg_s cfg_q;

  // ---------------------------------------------------------------------------
  // command fsm
  // ---------------------------------------------------------------------------

  // tx and rx frequency slots
  assign is_freq_addr = (cmd_addr_i >= `RADIO_ADDR_TXFREQ) &&
                        (cmd_addr_i <= `RADIO_ADDR_MAXFREQ);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        // control and vna writes finish in idle
        if (cmd_rqst_i && is_freq_addr) begin
          state_d = ST_FREQ1;
        end
      end
      ST_FREQ1: state_d = ST_FREQ2;
      ST_FREQ2: state_d = ST_FREQ3;
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      cfg_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == ST_IDLE && cmd_rqst_i) begin
        if (cmd_addr_i == `RADIO_ADDR_CTRL) begin
          cfg_q.rx_rate   <= cmd_data_i.ctrl.rx_rate;
          cfg_q.last_chan <= cmd_data_i.ctrl.last_chan;
          cfg_q.duplex    <= cmd_data_i.ctrl.duplex;
        end
        // only the constant carrier bit, no scanning
        if (cmd_addr_i == `RADIO_ADDR_VNA) begin
          cfg_q.vna <= cmd_data_i.ctrl.vna;
        end
      end
    end
  end

  // ---------------------------------------------------------------------------
  // frequency to phase increment
  // ---------------------------------------------------------------------------

  // host holds the data, so freq1 and freq2 give the multiplier two cycles
  assign freq_prod = {32'd0, cmd_data_i.freq} * {32'd0, `RADIO_FREQ_MULT} +
                     {32'd0, `RADIO_FREQ_ROUND};

  always_ff @(posedge clk) begin
    if (state_q == ST_FREQ2) begin
      phase_q <= freq_prod[56:25];
      addr_q  <= cmd_addr_i;
    end
  end

  // ack and write strobe share the freq3 cycle
  assign cmd_ack_o = (state_q == ST_FREQ3);
  assign freq_wr_o = '{valid: cmd_ack_o, addr: addr_q, phase: phase_q};
  assign cfg_o     = cfg_q;

  // decimation for the external receivers
  always_comb begin
    case (cfg_q.rx_rate)
      2'd0:    rate_o = `RADIO_RATE48;
      2'd1:    rate_o = `RADIO_RATE96;
      2'd2:    rate_o = `RADIO_RATE192;
      default: rate_o = `RADIO_RATE384;
    endcase
  end

endmodule

// ==== src/radio_cw_shaper.sv ====
`include "radio_consts.svh"

module radio_cw_shaper (
  input  logic        clk,
  input  logic        rst_i,
  input  logic        cw_keydown_i,
  output logic        cw_key_o,
  output logic [18:0] cw_level_o
);

  localparam logic [1:0] ST_IDLE = 2'b00;
  localparam logic [1:0] ST_DOWN = 2'b01;
  localparam logic [1:0] ST_UP   = 2'b11;

  logic [1:0] state_q;

  // ---------------------------------------------------------------------------
  // key ramp, linear rise and fall, one step per clock
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q    <= ST_IDLE;
      cw_level_o <= 19'd0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          cw_level_o <= 19'd0;
          if (cw_keydown_i) begin
            state_q <= ST_DOWN;
          end
        end
        ST_DOWN: begin
          // rise and hold at the top
          if (cw_level_o != `RADIO_CW_MAX) begin
            cw_level_o <= cw_level_o + 19'd1;
          end
          if (!cw_keydown_i) begin
            state_q <= ST_UP;
          end
        end
        default: begin
          // released, fall back to zero then drop the key
          if (cw_level_o == 19'd0) begin
            state_q <= ST_IDLE;
          end else begin
            cw_level_o <= cw_level_o - 19'd1;
          end
        end
      endcase
    end
  end

  assign cw_key_o = (state_q != ST_IDLE);

endmodule

// ==== src/radio_phase_bank.sv ====
`include "radio_consts.svh"

module radio_phase_bank (
  input  logic                   clk,
  input  logic                   rst_i,
  input  radio_pkg::radio_cfg_s  cfg_i,
  input  radio_pkg::freq_wr_s    freq_wr_i,
  output radio_pkg::phase_bank_s phase_o
);

  logic simplex_ch0;

  // single receiver on the tx frequency
  assign simplex_ch0 = !cfg_i.duplex && (cfg_i.last_chan == 5'd0);

  // ---------------------------------------------------------------------------
  // phase word registers
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst_i) begin
      phase_o <= '0;
    end else if (freq_wr_i.valid) begin
      // tx slot, rx0 follows in simplex
      if (freq_wr_i.addr == `RADIO_ADDR_TXFREQ) begin
        phase_o.tx <= freq_wr_i.phase;
        if (simplex_ch0) begin
          phase_o.rx[0] <= freq_wr_i.phase;
        end
      end

      // rx0 slot
      // simplex keeps rx0 locked to the current tx word
      if (freq_wr_i.addr == `RADIO_ADDR_RX0FREQ) begin
        if (simplex_ch0) begin
          phase_o.rx[0] <= phase_o.tx;
        end else begin
          phase_o.rx[0] <= freq_wr_i.phase;
        end
      end

      // remaining receivers at consecutive addresses
      for (int n = 1; n < `RADIO_NUM_RX; n++) begin
        if (freq_wr_i.addr == `RADIO_ADDR_RX0FREQ + 6'(n)) begin
          phase_o.rx[n] <= freq_wr_i.phase;
        end
      end
      // slots above the last receiver fall through unused
    end
  end

endmodule

// ==== src/radio_pkg.sv ====
`include "radio_consts.svh"

package radio_pkg;

  // control view of a command data word
  // unused fields kept so the view spans all 32 bits
  typedef struct packed {
    logic [5:0]  rsvd_31_26;
    logic [1:0]  rx_rate;
    logic        vna;
    logic [14:0] rsvd_22_8;
    logic [4:0]  last_chan;
    logic        duplex;
    logic [1:0]  rsvd_1_0;
  } ctrl_s;

  // same data word, read as control bits or as a frequency in Hz
  typedef union packed {
    ctrl_s       ctrl;
    logic [31:0] freq;
  } cmd_word_u;

  // registered configuration
  typedef struct packed {
    logic       vna;
    logic [1:0] rx_rate;
    logic [4:0] last_chan;
    logic       duplex;
  } radio_cfg_s;

  // one phase word write, valid for a single cycle
  typedef struct packed {
    logic        valid;
    logic [5:0]  addr;
    logic [31:0] phase;
  } freq_wr_s;

  // one decimated receiver sample
  typedef struct packed {
    logic [23:0] i;
    logic [23:0] q;
  } rx_sample_s;

  // all receivers, entry n is receiver n
  typedef struct packed {
    rx_sample_s [`RADIO_NUM_RX-1:0] ch;
  } rx_bank_s;

  // nco phase increments
  typedef struct packed {
    logic [31:0]                    tx;
    logic [`RADIO_NUM_RX-1:0][31:0] rx;
  } phase_bank_s;

  // baseband i/q to the modulator
  typedef struct packed {
    logic signed [15:0] i;
    logic signed [15:0] q;
  } tx_iq_s;

endpackage

// ==== src/radio_rx_upstream.sv ====
`include "radio_consts.svh"

module radio_rx_upstream (
  input  logic                clk,
  input  logic                rst_i,
  input  logic [4:0]          last_chan_i,
  input  logic                rx_strobe_i,
  input  radio_pkg::rx_bank_s rx_bank_i,
  output logic [23:0]         rx_tdata_o,
  output logic                rx_tvalid_o,
  output logic                rx_tlast_o,
  input  logic                rx_tready_i
);

  localparam logic [1:0] ST_WAIT1 = 2'b00;
  localparam logic [1:0] ST_I     = 2'b10;
  localparam logic [1:0] ST_Q     = 2'b11;
  localparam logic [1:0] ST_WAIT0 = 2'b01;

  logic [1:0]            state_q;
  logic [4:0]            chan_q;
  logic                  chan_last;
  radio_pkg::rx_bank_s   bank_q;
  radio_pkg::rx_sample_s sample;

  assign chan_last = (chan_q == last_chan_i);

  // ---------------------------------------------------------------------------
  // packet fsm
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= ST_WAIT1;
      chan_q  <= 5'd0;
    end else begin
      case (state_q)
        ST_WAIT1: begin
          chan_q <= 5'd0;
          if (rx_strobe_i && rx_tready_i) begin
            state_q <= ST_I;
          end
        end
        // each beat advances only on an accepted transfer
        ST_I: begin
          if (rx_tready_i) begin
            state_q <= ST_Q;
          end
        end
        ST_Q: begin
          if (rx_tready_i) begin
            if (chan_last) begin
              state_q <= ST_WAIT0;
            end else begin
              chan_q  <= chan_q + 5'd1;
              state_q <= ST_I;
            end
          end
        end
        default: begin
          // strobe must drop before the next packet
          chan_q <= 5'd0;
          if (!rx_strobe_i) begin
            state_q <= ST_WAIT1;
          end
        end
      endcase
    end
  end

  // snapshot at packet start, beats stay stable under back-pressure
  always_ff @(posedge clk) begin
    if (state_q == ST_WAIT1 && rx_strobe_i && rx_tready_i) begin
      bank_q <= rx_bank_i;
    end
  end

  // channel select, zero past the last receiver
  always_comb begin
    sample = '0;
    for (int n = 0; n < `RADIO_NUM_RX; n++) begin
      if (chan_q == 5'(n)) begin
        sample = bank_q.ch[n];
      end
    end
  end

  assign rx_tvalid_o = (state_q == ST_I) || (state_q == ST_Q);
  assign rx_tlast_o  = (state_q == ST_Q) && chan_last;
  assign rx_tdata_o  = (state_q == ST_Q) ? sample.q : sample.i;

endmodule

// ==== src/radio_top.sv ====
module radio_top (
  input  logic                   clk,
  input  logic                   rst_i,

  // command slave
  input  logic                   cmd_rqst_i,
  input  logic [5:0]             cmd_addr_i,
  input  radio_pkg::cmd_word_u   cmd_data_i,
  output logic                   cmd_ack_o,

  // cw key
  input  logic                   cw_keydown_i,
  output logic                   tx_cw_key_o,

  // downstream baseband
  input  radio_pkg::tx_iq_s      tx_tdata_i,
  input  logic                   tx_tvalid_i,
  input  logic                   tx_req_i,
  output logic                   tx_tready_o,
  output logic                   tx_hang_o,
  output radio_pkg::tx_iq_s      tx_iq_o,

  // receiver samples and upstream stream
  input  logic                   rx_strobe_i,
  input  radio_pkg::rx_bank_s    rx_bank_i,
  output logic [23:0]            rx_tdata_o,
  output logic                   rx_tvalid_o,
  output logic                   rx_tlast_o,
  input  logic                   rx_tready_i,

  // nco and decimator setup
  output radio_pkg::phase_bank_s phase_o,
  output logic [5:0]             rate_o
);

  radio_pkg::radio_cfg_s cfg;
  radio_pkg::freq_wr_s   freq_wr;
  logic [18:0]           cw_level;

  radio_cmd_slave i_cmd_slave (
    .clk        (clk),
    .rst_i      (rst_i),
    .cmd_rqst_i (cmd_rqst_i),
    .cmd_addr_i (cmd_addr_i),
    .cmd_data_i (cmd_data_i),
    .cmd_ack_o  (cmd_ack_o),
    .cfg_o      (cfg),
    .freq_wr_o  (freq_wr),
    .rate_o     (rate_o)
  );

  radio_phase_bank i_phase_bank (
    .clk       (clk),
    .rst_i     (rst_i),
    .cfg_i     (cfg),
    .freq_wr_i (freq_wr),
    .phase_o   (phase_o)
  );

  radio_rx_upstream i_rx_upstream (
    .clk         (clk),
    .rst_i       (rst_i),
    .last_chan_i (cfg.last_chan),
    .rx_strobe_i (rx_strobe_i),
    .rx_bank_i   (rx_bank_i),
    .rx_tdata_o  (rx_tdata_o),
    .rx_tvalid_o (rx_tvalid_o),
    .rx_tlast_o  (rx_tlast_o),
    .rx_tready_i (rx_tready_i)
  );

  radio_cw_shaper i_cw_shaper (
    .clk          (clk),
    .rst_i        (rst_i),
    .cw_keydown_i (cw_keydown_i),
    .cw_key_o     (tx_cw_key_o),
    .cw_level_o   (cw_level)
  );

  radio_tx_baseband i_tx_baseband (
    .clk         (clk),
    .rst_i       (rst_i),
    .vna_i       (cfg.vna),
    .cw_key_i    (tx_cw_key_o),
    .cw_level_i  (cw_level),
    .tx_tdata_i  (tx_tdata_i),
    .tx_tvalid_i (tx_tvalid_i),
    .tx_req_i    (tx_req_i),
    .tx_tready_o (tx_tready_o),
    .tx_hang_o   (tx_hang_o),
    .tx_iq_o     (tx_iq_o)
  );

endmodule

// ==== src/radio_tx_baseband.sv ====
`include "radio_consts.svh"

module radio_tx_baseband (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              vna_i,
  input  logic              cw_key_i,
  input  logic [18:0]       cw_level_i,
  input  radio_pkg::tx_iq_s tx_tdata_i,
  input  logic              tx_tvalid_i,
  input  logic              tx_req_i,
  output logic              tx_tready_o,
  output logic              tx_hang_o,
  output radio_pkg::tx_iq_s tx_iq_o
);

  radio_pkg::tx_iq_s sample_q;

  // interpolator pulls one sample per request
  assign tx_tready_o = tx_req_i;
  // hold tx on while the host still has samples queued
  assign tx_hang_o   = tx_tvalid_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      sample_q <= '0;
    end else if (tx_tvalid_i && tx_tready_o) begin
      sample_q <= tx_tdata_i;
    end
  end

  // ---------------------------------------------------------------------------
  // modulator word select
  // ---------------------------------------------------------------------------

  // vna carrier first, then cw level, then the sample
  // cw level scaled down by 16, sign bit kept clear
  assign tx_iq_o.i = vna_i    ? `RADIO_VNA_LEVEL :
                     cw_key_i ? {1'b0, cw_level_i[18:4]} :
                                sample_q.i;
  assign tx_iq_o.q = (vna_i || cw_key_i) ? 16'sd0 : sample_q.q;

endmodule
